/* hw/audio_defs.svh */
`ifndef AUDIO_DEFS_SVH
`define AUDIO_DEFS_SVH

// microphone channels in the array
`define MIC_COUNT 4

// audio_clk cycles per half bit clock, one bit = 32 cycles
`define BCLK_HALF 16

// bit clocks per I2S frame, left slot + right slot
`define FRAME_BITS 64

// data bits the microphone sends per word
`define MIC_BITS 18

// width of an audio sample after truncation
`define SAMPLE_BITS 16

// right shift applied to the DC tracking error
`define DC_SHIFT 8

`endif

/* hw/audio_pkg.sv */
`include "audio_defs.svh"

package audio_pkg;

  // one signed audio sample
  typedef logic signed [`SAMPLE_BITS-1:0] sample_t;

  typedef logic [$clog2(`FRAME_BITS)-1:0] bit_idx_t; // position inside an I2S frame

  typedef struct packed {
    logic    valid; // one-cycle pulse, data held until the next one
    sample_t data;
  } mic_sample_t;

  typedef struct packed {
    logic     bclk;
    logic     lrcl;          // low during the left slot
    logic     bit_strobe;    // coincides with bclk rising
    bit_idx_t bit_index;
    logic     frame_trigger; // bit_index just wrapped to 0
  } i2s_timing_t;

  typedef struct packed {
    logic       dc_enable;
    logic [1:0] gain_shift; // left shift 0..3
  } chan_cfg_t;

  localparam logic signed [31:0] SAMPLE_MAX = (32'sd1 <<< (`SAMPLE_BITS - 1)) - 32'sd1;
  localparam logic signed [31:0] SAMPLE_MIN = -(32'sd1 <<< (`SAMPLE_BITS - 1));

  // clip a wide signed value into the sample range
  function automatic sample_t sat_sample(input logic signed [31:0] value);
    if (value > SAMPLE_MAX) return sample_t'(SAMPLE_MAX);
    if (value < SAMPLE_MIN) return sample_t'(SAMPLE_MIN);
    return sample_t'(value);
  endfunction

endpackage

/* hw/i2s_clock_gen.sv */
`timescale 1ns/10ps
`include "audio_defs.svh"

module i2s_clock_gen (
  input  logic                   audio_clk,
  input  logic                   rst_n,
  output audio_pkg::i2s_timing_t timing
);
  import audio_pkg::*;

  localparam int HALF_W = $clog2(`BCLK_HALF);
  localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(`BCLK_HALF - 1);
  localparam bit_idx_t LAST_BIT = bit_idx_t'(`FRAME_BITS - 1);
  localparam bit_idx_t RIGHT_START = bit_idx_t'(`FRAME_BITS / 2);

  logic [HALF_W-1:0] half_cnt;
  logic              bclk_q;
  logic              strobe_q;
  logic              trigger_q;
  bit_idx_t          bit_idx;
  logic              half_done;

  assign half_done = (half_cnt == HALF_LAST);

  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      half_cnt  <= '0;
      bclk_q    <= 1'b0;
      strobe_q  <= 1'b0;
      trigger_q <= 1'b0;
      bit_idx   <= '0;
    end else begin
      strobe_q  <= 1'b0;
      trigger_q <= 1'b0;
      if (half_done) begin
        half_cnt <= '0;
        bclk_q   <= ~bclk_q;
        if (!bclk_q) begin
          strobe_q <= 1'b1; // rising edge, middle of the bit
        end else begin
          // falling edge opens the next bit period
          bit_idx   <= bit_idx + 1'b1;
          trigger_q <= (bit_idx == LAST_BIT);
        end
      end else begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  assign timing.bclk          = bclk_q;
  assign timing.lrcl          = (bit_idx >= RIGHT_START); // right slot in upper half
  assign timing.bit_strobe    = strobe_q;
  assign timing.bit_index     = bit_idx;
  assign timing.frame_trigger = trigger_q;

  // consecutive strobes are one bit apart and see consecutive indices
  a_index_step: assert property (@(posedge audio_clk) disable iff (!rst_n)
    timing.bit_strobe |-> ##(2*`BCLK_HALF)
      (timing.bit_strobe && timing.bit_index == $past(timing.bit_index, 2*`BCLK_HALF) + 1'b1));

  a_trigger_at_zero: assert property (@(posedge audio_clk) disable iff (!rst_n)
    timing.frame_trigger |-> (timing.bit_index == '0));

endmodule

/* hw/mic_channel.sv */
`timescale 1ns/10ps
`include "audio_defs.svh"

module mic_channel (
  input  logic                   audio_clk,
  input  logic                   rst_n,
  input  audio_pkg::i2s_timing_t timing,
  input  logic                   mic_data,
  input  audio_pkg::chan_cfg_t   cfg,
  output audio_pkg::mic_sample_t sample
);
  import audio_pkg::*;

  localparam bit_idx_t FIRST_BIT = bit_idx_t'(1);        // MSB arrives one bit after lrcl falls
  localparam bit_idx_t LAST_BIT  = bit_idx_t'(`MIC_BITS);
  localparam bit_idx_t LATCH_BIT = bit_idx_t'(`FRAME_BITS / 2);

  logic [`MIC_BITS-1:0] shift_q;
  logic                 capture;
  logic                 latch;
  sample_t              raw;
  sample_t              dc_avg;
  logic signed [31:0]   diff;
  logic signed [31:0]   dc_step;
  logic signed [31:0]   gained;

  // left slot data bits sampled on the bclk rise
  assign capture = timing.bit_strobe && !timing.lrcl &&
                   (timing.bit_index >= FIRST_BIT) && (timing.bit_index <= LAST_BIT);

  // word is long complete by the first strobe of the right slot
  assign latch = timing.bit_strobe && (timing.bit_index == LATCH_BIT);

  always_ff @(posedge audio_clk) begin
    if (capture) begin
      shift_q <= {shift_q[`MIC_BITS-2:0], mic_data}; // MSB first
    end
  end

  // top of the word without the two LSBs
  assign raw = sample_t'(shift_q[`MIC_BITS-1 -: `SAMPLE_BITS]);

  always_comb begin
    diff    = 32'(raw) - 32'(dc_avg); // dc_avg is zero when removal is off
    dc_step = diff >>> `DC_SHIFT;
    gained  = diff <<< cfg.gain_shift;
  end

  // tracking average of the input moves a fraction of the error per sample
  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      dc_avg <= '0;
    end else if (!cfg.dc_enable) begin
      dc_avg <= '0;
    end else if (latch) begin
      dc_avg <= sample_t'(32'(dc_avg) + dc_step);
    end
  end

  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      sample <= '0;
    end else begin
      sample.valid <= latch;
      if (latch) begin
        sample.data <= sat_sample(gained);
      end
    end
  end

  // one word per frame so the pulse never stretches
  a_valid_single: assert property (@(posedge audio_clk) disable iff (!rst_n)
    sample.valid |=> !sample.valid);

endmodule

/* hw/mic_mixer.sv */
`timescale 1ns/10ps
`include "audio_defs.svh"

module mic_mixer (
  input  logic                   audio_clk,
  input  logic                   rst_n,
  input  audio_pkg::i2s_timing_t timing,
  input  audio_pkg::mic_sample_t chan_samples [`MIC_COUNT],
  input  logic [`MIC_COUNT-1:0]  chan_enable,
  output audio_pkg::mic_sample_t mix
);
  import audio_pkg::*;

  sample_t            held [`MIC_COUNT]; // latest sample per channel
  logic signed [31:0] sum;

  always_ff @(posedge audio_clk) begin
    for (int i = 0; i < `MIC_COUNT; i++) begin
      if (!rst_n) begin
        held[i] <= '0;
      end else if (chan_samples[i].valid) begin
        held[i] <= chan_samples[i].data;
      end
    end
  end

  // plenty of headroom, clipping happens once at the end
  always_comb begin
    sum = '0;
    for (int i = 0; i < `MIC_COUNT; i++) begin
      if (chan_enable[i]) begin
        sum = sum + 32'(held[i]);
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      mix <= '0;
    end else begin
      mix.valid <= timing.frame_trigger;
      if (timing.frame_trigger) begin
        mix.data <= sat_sample(sum); // held until next frame
      end
    end
  end

  a_mix_follows_trigger: assert property (@(posedge audio_clk) disable iff (!rst_n)
    mix.valid == $past(timing.frame_trigger));

endmodule

/* hw/pdm_modulator.sv */
`timescale 1ns/10ps
`include "audio_defs.svh"

module pdm_modulator (
  input  logic               audio_clk,
  input  logic               rst_n,
  input  audio_pkg::sample_t level,
  output logic               pdm_out
);

  logic [`SAMPLE_BITS-1:0] offset;
  logic [`SAMPLE_BITS-1:0] acc;
  logic [`SAMPLE_BITS:0]   acc_sum;

  // flip the sign bit, -32768 maps to 0 and 32767 to 65535
  assign offset = {~level[`SAMPLE_BITS-1], level[`SAMPLE_BITS-2:0]};

  assign acc_sum = {1'b0, acc} + {1'b0, offset};

  // carry out of the accumulator is the one-bit stream
  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      acc     <= '0;
      pdm_out <= 1'b0;
    end else begin
      acc     <= acc_sum[`SAMPLE_BITS-1:0];
      pdm_out <= acc_sum[`SAMPLE_BITS];
    end
  end

endmodule

/* hw/mic_array_top.sv */
`timescale 1ns/10ps
`include "audio_defs.svh"

module mic_array_top (
  input  logic                   audio_clk,
  input  logic                   rst_n,
  input  logic [`MIC_COUNT-1:0]  mic_data,
  output logic                   bclk,
  output logic                   lrcl,
  input  audio_pkg::chan_cfg_t   chan_cfg [`MIC_COUNT],
  input  logic [`MIC_COUNT-1:0]  chan_enable,
  output audio_pkg::mic_sample_t mix,
  output logic                   pdm_out
);
  import audio_pkg::*;

  i2s_timing_t timing;
  mic_sample_t chan_samples [`MIC_COUNT];

  i2s_clock_gen u_clock_gen (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .timing    (timing)
  );

  // all mics share one bit clock and word select
  assign bclk = timing.bclk;
  assign lrcl = timing.lrcl;

  for (genvar i = 0; i < `MIC_COUNT; i++) begin : g_chan
    mic_channel u_chan (
      .audio_clk (audio_clk),
      .rst_n     (rst_n),
      .timing    (timing),
      .mic_data  (mic_data[i]),
      .cfg       (chan_cfg[i]),
      .sample    (chan_samples[i])
    );
  end

  mic_mixer u_mixer (
    .audio_clk    (audio_clk),
    .rst_n        (rst_n),
    .timing       (timing),
    .chan_samples (chan_samples),
    .chan_enable  (chan_enable),
    .mix          (mix)
  );

  pdm_modulator u_pdm (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .level     (mix.data), // held level between frames
    .pdm_out   (pdm_out)
  );

endmodule

/* bench/i2s_mic_model.sv */
`timescale 1ns/10ps
`include "audio_defs.svh"

module i2s_mic_model (
  input  logic bclk,
  input  logic lrcl,
  output logic sd
);

  logic [`MIC_BITS-1:0] word; // word sent in every left slot
  int                   pos;  // bit period inside the left slot, 0 when lrcl falls

  initial begin
    word = '0;
    pos  = 0;
    sd   = 1'b0;
  end

  task automatic set_word(input logic [`MIC_BITS-1:0] value);
    word = value;
  endtask

  // the mic changes data after the falling bclk
  always @(negedge bclk) begin
    #1; // let lrcl settle, it moves on the same edge
    if (lrcl) begin
      pos = -1; // right slot, the mic stays quiet
    end else begin
      pos = pos + 1;
    end
    if (!lrcl && pos >= 1 && pos <= `MIC_BITS) begin
      sd = word[`MIC_BITS - pos]; // MSB one bit after lrcl falls
    end else begin
      sd = 1'b0;
    end
  end

endmodule

/* bench/mic_array_tb.sv */
`timescale 1ns/10ps
`include "audio_defs.svh"

module mic_array_tb;
  import audio_pkg::*;

  localparam int SEED_START     = 33515;
  localparam int TIMEOUT_CYCLES = 150000; // about 63 frames of 2048 cycles, plus margin
  localparam int PDM_WINDOW     = 65536;
  localparam int PDM_TOL        = 2;

  logic                  audio_clk;
  logic                  rst_n;
  wire [`MIC_COUNT-1:0]  mic_data;
  logic                  bclk;
  logic                  lrcl;
  chan_cfg_t             chan_cfg [`MIC_COUNT];
  logic [`MIC_COUNT-1:0] chan_enable;
  mic_sample_t           mix;
  logic                  pdm_out;

  logic [`MIC_BITS-1:0]  mic_words [`MIC_COUNT]; // word each model sends
  int                    seed;
  int                    errors;
  int                    checks;
  int                    cycles;

  mic_array_top DUT (
    .audio_clk   (audio_clk),
    .rst_n       (rst_n),
    .mic_data    (mic_data),
    .bclk        (bclk),
    .lrcl        (lrcl),
    .chan_cfg    (chan_cfg),
    .chan_enable (chan_enable),
    .mix         (mix),
    .pdm_out     (pdm_out)
  );

  for (genvar i = 0; i < `MIC_COUNT; i++) begin : g_mic
    i2s_mic_model u_mic (
      .bclk (bclk),
      .lrcl (lrcl),
      .sd   (mic_data[i])
    );
    always @(mic_words[i]) u_mic.set_word(mic_words[i]);
  end

  always #10 audio_clk = ~audio_clk;

  always @(posedge audio_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: no result after %0d audio_clk cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic compare(input string name, input logic signed [31:0] expected,
                         input logic signed [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error [%0t] %s: expected %0d, actual %0d", $time, name, expected, actual);
    end
  endtask

  // top 16 bits of the mic word as a signed sample
  function automatic int top_bits(input logic [`MIC_BITS-1:0] word);
    logic signed [15:0] t;
    t = word[`MIC_BITS-1 -: 16];
    return t;
  endfunction

  function automatic int clip16(input int value);
    if (value > 32767) return 32767;
    if (value < -32768) return -32768;
    return value;
  endfunction

  function automatic logic [`MIC_BITS-1:0] make_word(input int raw, input logic [1:0] lsbs);
    logic [15:0] r16;
    r16 = raw[15:0];
    return {r16, lsbs};
  endfunction

  function automatic logic [`MIC_BITS-1:0] random_word();
    int r;
    r = $random(seed);
    return r[`MIC_BITS-1:0];
  endfunction

  // valid only with dc removal off in every enabled channel
  function automatic int expected_mix();
    int sum;
    sum = 0;
    for (int i = 0; i < `MIC_COUNT; i++) begin
      if (chan_enable[i]) begin
        sum += clip16(top_bits(mic_words[i]) <<< chan_cfg[i].gain_shift);
      end
    end
    return clip16(sum);
  endfunction

  task automatic wait_mix();
    do begin
      @(posedge audio_clk);
      #1;
    end while (!mix.valid);
  endtask

  // called right after a mix pulse, two pulses later the new words have reached mix
  task automatic wait_frames(input int n);
    repeat (n) wait_mix();
  endtask

  task automatic set_config(input logic [`MIC_COUNT-1:0] enable, input logic [1:0] gain,
                            input logic dc);
    chan_enable = enable;
    for (int i = 0; i < `MIC_COUNT; i++) begin
      chan_cfg[i].gain_shift = gain;
      chan_cfg[i].dc_enable  = dc;
    end
  endtask

  task automatic reset_state();
    int   toggles;
    logic last_bclk;
    repeat (16) begin
      @(posedge audio_clk);
      #1;
      compare("reset bclk", 0, bclk);
      compare("reset lrcl", 0, lrcl);
      compare("reset mix valid", 0, mix.valid);
      compare("reset pdm_out", 0, pdm_out);
    end
    rst_n = 1'b1;
    @(posedge audio_clk);
    #1;
    compare("after reset lrcl", 0, lrcl);
    compare("after reset mix valid", 0, mix.valid);
    compare("after reset pdm_out", 0, pdm_out);
    toggles   = 0;
    last_bclk = bclk;
    repeat (4 * `BCLK_HALF) begin
      @(posedge audio_clk);
      #1;
      if (bclk !== last_bclk) toggles++;
      last_bclk = bclk;
    end
    compare("bclk toggles", 4, toggles); // one edge per half period
  endtask

  task automatic passthrough();
    set_config('b1, 2'd0, 1'b0);
    for (int i = 0; i < `MIC_COUNT; i++) mic_words[i] = random_word();
    mic_words[0] = make_word(1234, 2'b01);
    wait_frames(2);
    compare("passthrough fixed", expected_mix(), mix.data);
    repeat (2) begin
      mic_words[0] = random_word();
      wait_frames(2);
      compare("passthrough random", expected_mix(), mix.data);
    end
  endtask

  task automatic gain_saturation();
    mic_words[0] = make_word(3000, 2'b10);
    for (int g = 1; g <= 3; g++) begin
      set_config('b1, 2'(g), 1'b0);
      wait_frames(2);
      compare("gain shift", expected_mix(), mix.data);
    end
    set_config('b1, 2'd2, 1'b0);
    mic_words[0] = make_word(20000, 2'b01);
    wait_frames(2);
    compare("gain clip high", 32767, mix.data);
    mic_words[0] = make_word(-20000, 2'b11);
    wait_frames(2);
    compare("gain clip low", -32768, mix.data);
  endtask

  task automatic mixing();
    set_config('1, 2'd0, 1'b0);
    for (int i = 0; i < `MIC_COUNT; i++) mic_words[i] = random_word();
    wait_frames(2);
    compare("mix all channels", expected_mix(), mix.data);
    chan_enable[2] = 1'b0;
    wait_frames(2);
    compare("mix channel 2 off", expected_mix(), mix.data);
  endtask

  task automatic dc_removal();
    int raw;
    int avg;
    int first_out;
    int last_out;
    raw = 20000;
    set_config('b1, 2'd0, 1'b0);
    mic_words[0] = make_word(raw, 2'b00);
    wait_frames(2);
    chan_cfg[0].dc_enable = 1'b1; // takes effect at this frame's latch
    avg       = 0;
    first_out = 0;
    last_out  = 0;
    for (int n = 0; n < 6; n++) begin
      wait_mix();
      compare("dc removal", clip16(raw - avg), mix.data);
      if (n == 0) first_out = mix.data;
      last_out = mix.data;
      avg = avg + ((raw - avg) >>> `DC_SHIFT);
    end
    compare("dc output shrinks", 1, last_out < first_out);
    chan_cfg[0].dc_enable = 1'b0;
  endtask

  task automatic pdm_density();
    int level;
    int ones;
    int expected;
    int diff;
    level = 8192;
    set_config('b1, 2'd0, 1'b0);
    mic_words[0] = make_word(level, 2'b00);
    wait_frames(2);
    expected = level + 32768; // offset binary, ones per 65536 cycles
    ones     = 0;
    repeat (PDM_WINDOW) begin
      @(posedge audio_clk);
      #1;
      ones += pdm_out;
    end
    diff = ones - expected;
    compare("pdm density", expected, (diff <= PDM_TOL && diff >= -PDM_TOL) ? expected : ones);
  endtask

  initial begin
    audio_clk   = 1'b0;
    rst_n       = 1'b0;
    chan_enable = '0;
    for (int i = 0; i < `MIC_COUNT; i++) begin
      chan_cfg[i]  = '0;
      mic_words[i] = '0;
    end
    seed   = SEED_START;
    errors = 0;
    checks = 0;
    cycles = 0;

    reset_state();
    wait_mix(); // line up with the first frame
    passthrough();
    gain_saturation();
    mixing();
    dc_removal();
    pdm_density();

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+hw
hw/audio_pkg.sv
hw/i2s_clock_gen.sv
hw/mic_channel.sv
hw/mic_mixer.sv
hw/pdm_modulator.sv
hw/mic_array_top.sv
bench/i2s_mic_model.sv
bench/mic_array_tb.sv
